/* logic/fetch_pkg.sv */
package fetch_pkg;

  // core side widths
  localparam int XLEN   = 64;   // pc and address width
  localparam int INST_W = 32;   // one rv instruction

  // pc steps one instruction at a time, no compressed support
  localparam int INST_BYTES = INST_W / 8;

  // first fetch after reset, start of dram in the usual memory map
  localparam logic [XLEN-1:0] RESET_PC = 64'h0000_0000_8000_0000;

  // addi x0, x0, 0
  // decode sees this as a bubble
  localparam logic [INST_W-1:0] NOP_INST = 32'h0000_0013;

endpackage

/* logic/bus_pkg.sv */
package bus_pkg;

  // read bus data width, one beat
  localparam int BUS_DW = 64;

  // axi id and len field widths
  localparam int BUS_ID_W  = 4;
  localparam int AXI_LEN_W = 8;   // len is beats minus one

  // transaction ids, also used to steer returning beats
  typedef enum logic [BUS_ID_W-1:0] {
    ID_NONE   = 4'd0,   // nobody owns the bus
    ID_IFETCH = 4'd1,   // icache line refill
    ID_LOAD   = 4'd2    // uncached data-stage load
  } bus_id_e;

  // arburst encodings, only incr is issued
  localparam logic [1:0] BURST_INCR = 2'b01;

  // rresp
  localparam logic [1:0] RESP_OKAY = 2'b00;

endpackage

/* logic/pc_gen.sv */
module pc_gen import fetch_pkg::*; #(
  parameter int FETCH_CREDITS = 4     // decode buffer depth
) (
  input  logic            clk,
  input  logic            rst_n,
  input  logic            redirect_valid_i,   // from execute
  input  logic [XLEN-1:0] redirect_pc_i,
  input  logic            inst_credit_i,      // decode consumed one
  input  logic            fetch_done_i,       // icache answered
  output logic            fetch_req_o,
  output logic [XLEN-1:0] fetch_addr_o,
  output logic            fetch_kill_o,
  output logic            deliver_o           // qualifies fetch_done for decode
);

  localparam int CRED_W = $clog2(FETCH_CREDITS + 1);

  logic [XLEN-1:0]   pc_q;          // next address to issue
  logic [CRED_W-1:0] credit_q;      // free slots in decode buffer
  logic              in_flight_q;   // icache takes one fetch at a time
  logic              can_issue;
  logic              issue;
  logic              squash;

  // a slot frees up in the same cycle the icache answers, so hits stream
  assign can_issue = (credit_q != '0) && (!in_flight_q || fetch_done_i);
  assign issue     = can_issue && !redirect_valid_i;   // hold off during redirect

  // outstanding fetch belongs to the old path
  assign squash    = redirect_valid_i && in_flight_q;

  assign fetch_req_o  = issue;
  assign fetch_addr_o = pc_q;   // also one past the fetch in flight
  assign fetch_kill_o = squash;
  assign deliver_o    = !squash;  // a hit landing in the redirect cycle is dropped

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      pc_q        <= RESET_PC;
      credit_q    <= CRED_W'(FETCH_CREDITS);
      in_flight_q <= 1'b0;
    end else begin
      // spend on issue, refill from decode, reclaim what got squashed
      credit_q <= credit_q - CRED_W'(issue) + CRED_W'(inst_credit_i) + CRED_W'(squash);

      if (redirect_valid_i) begin
        pc_q        <= redirect_pc_i;
        in_flight_q <= 1'b0;            // icache drops the killed one
      end else if (issue) begin
        pc_q        <= pc_q + XLEN'(INST_BYTES);   // pc+4, no prediction
        in_flight_q <= 1'b1;
      end else if (fetch_done_i) begin
        in_flight_q <= 1'b0;
      end
    end
  end

  // decode must never hand back more than it was given
  a_credit_bound: assert property (@(posedge clk) disable iff (!rst_n)
    credit_q <= CRED_W'(FETCH_CREDITS))
    else $error("pc_gen: credit count above %0d", FETCH_CREDITS);

endmodule

/* logic/icache.sv */
module icache import fetch_pkg::*, bus_pkg::*; #(
  parameter int NUM_LINES  = 16,
  parameter int LINE_BEATS = 2    // power of two, at least 2
) (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              fetch_req_i,
  input  logic [XLEN-1:0]   fetch_addr_i,
  input  logic              fetch_kill_i,
  output logic              fetch_done_o,
  output logic [INST_W-1:0] fetch_word_o,
  output logic              refill_req_o,
  output logic [XLEN-1:0]   refill_addr_o,
  input  logic              refill_gnt_i,
  input  logic              refill_beat_valid_i,
  input  logic [BUS_DW-1:0] refill_data_i,
  input  logic              refill_last_i
);

  localparam int BEAT_OFF = $clog2(BUS_DW / 8);              // byte bits in one beat
  localparam int BEAT_W   = $clog2(LINE_BEATS);
  localparam int OFF_W    = $clog2(LINE_BEATS * BUS_DW / 8); // byte bits in one line
  localparam int IDX_W    = $clog2(NUM_LINES);
  localparam int TAG_W    = XLEN - OFF_W - IDX_W;

  typedef enum logic [1:0] {S_IDLE, S_REQ, S_FILL} state_e;

  state_e            state_q;
  logic              req_q;         // lookup pending in S_IDLE
  logic              live_q;        // refill still has someone waiting
  logic              live_d;
  logic [BEAT_W-1:0] beat_q;        // next beat slot to write
  logic [XLEN-1:0]   addr_q;        // address being looked up
  logic [XLEN-1:0]   fill_addr_q;   // line being refilled, kept apart from addr_q

  logic [NUM_LINES-1:0] valid_q;
  logic [TAG_W-1:0]     tag_mem  [NUM_LINES];
  logic [BUS_DW-1:0]    data_mem [NUM_LINES*LINE_BEATS];

  logic [IDX_W-1:0]  idx_q;
  logic [TAG_W-1:0]  tag_q;
  logic [BEAT_W-1:0] beat_sel;
  logic [IDX_W-1:0]  fill_idx;
  logic [BUS_DW-1:0] rd_beat;
  logic              tag_match;
  logic              miss;

  // split the lookup address
  assign idx_q    = addr_q[OFF_W +: IDX_W];
  assign tag_q    = addr_q[XLEN-1 -: TAG_W];
  assign beat_sel = addr_q[BEAT_OFF +: BEAT_W];
  assign fill_idx = fill_addr_q[OFF_W +: IDX_W];

  assign tag_match = valid_q[idx_q] && (tag_mem[idx_q] == tag_q);
  assign rd_beat   = data_mem[{idx_q, beat_sel}];
  assign miss      = (state_q == S_IDLE) && req_q && !tag_match;

  assign fetch_done_o = (state_q == S_IDLE) && req_q && tag_match;
  assign fetch_word_o = addr_q[2] ? rd_beat[BUS_DW-1 -: INST_W] : rd_beat[INST_W-1:0];

  assign refill_req_o  = (state_q == S_REQ);
  assign refill_addr_o = {fill_addr_q[XLEN-1:OFF_W], {OFF_W{1'b0}}};   // line aligned

  // a kill empties the waiting slot, the redirect target may then take it
  assign live_d = fetch_kill_i ? 1'b0 : (fetch_req_i || live_q);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= S_IDLE;
      req_q   <= 1'b0;
      live_q  <= 1'b0;
      beat_q  <= '0;
      valid_q <= '0;
    end else begin
      case (state_q)
        S_IDLE: begin
          if (miss && !fetch_kill_i) begin
            state_q <= S_REQ;       // keep req_q, replay after fill
            live_q  <= 1'b1;
            beat_q  <= '0;
          end else begin
            req_q <= fetch_req_i;   // pipelined, one lookup per cycle
          end
        end
        S_REQ: begin
          live_q <= live_d;
          if (refill_gnt_i) state_q <= S_FILL;
        end
        S_FILL: begin
          live_q <= live_d;
          if (refill_beat_valid_i) begin
            beat_q <= beat_q + 1'b1;    // beats come in address order
            if (refill_last_i) begin
              valid_q[fill_idx] <= 1'b1;
              state_q           <= S_IDLE;
              req_q             <= live_d;   // killed fetch gets no done
            end
          end
        end
        default: state_q <= S_IDLE;
      endcase
    end
  end

  // arrays and address registers
  always_ff @(posedge clk) begin
    if (fetch_req_i) addr_q <= fetch_addr_i;
    if (miss) fill_addr_q <= addr_q;
    if (state_q == S_FILL && refill_beat_valid_i) begin
      data_mem[{fill_idx, beat_q}] <= refill_data_i;
      if (refill_last_i) tag_mem[fill_idx] <= fill_addr_q[XLEN-1 -: TAG_W];
    end
  end

  // pc_gen may only issue over a refill whose own fetch was killed
  a_no_req_in_refill: assert property (@(posedge clk) disable iff (!rst_n)
    (state_q != S_IDLE && fetch_req_i) |-> !live_q)
    else $error("icache: new fetch while a live refill is running");

endmodule

/* logic/mem_arbiter.sv */
module mem_arbiter import fetch_pkg::*, bus_pkg::*; #(
  parameter int LINE_BEATS = 2
) (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 refill_req_i,
  input  logic [XLEN-1:0]      refill_addr_i,
  output logic                 refill_gnt_o,
  input  logic                 ld_req_i,       // held until ld_gnt_o
  input  logic [XLEN-1:0]      ld_addr_i,
  output logic                 ld_gnt_o,
  output logic                 bus_req_o,
  output logic [XLEN-1:0]      bus_addr_o,
  output bus_id_e              bus_id_o,
  output logic [AXI_LEN_W-1:0] bus_len_o,
  input  logic                 bus_gnt_i,
  input  logic                 beat_valid_i,
  input  bus_id_e              beat_id_i,
  input  logic [BUS_DW-1:0]    beat_data_i,
  input  logic                 beat_last_i,
  output logic                 refill_beat_valid_o,
  output logic                 ld_rvalid_o,
  output logic [BUS_DW-1:0]    ld_rdata_o
);

  bus_id_e owner_q;   // ID_NONE while the bus is free
  logic    pick_refill;

  // fixed priority, icache first so fetch is not starved by loads
  assign pick_refill = refill_req_i;

  // nothing new until the owner's last beat is back
  assign bus_req_o = (owner_q == ID_NONE) && (refill_req_i || ld_req_i);

  always_comb begin
    if (pick_refill) begin
      bus_addr_o = refill_addr_i;                     // already line aligned
      bus_id_o   = ID_IFETCH;
      bus_len_o  = AXI_LEN_W'(LINE_BEATS - 1);
    end else begin
      bus_addr_o = ld_addr_i;
      bus_id_o   = ID_LOAD;
      bus_len_o  = '0;                                // single beat
    end
  end

  // the master grants only while idle and requested
  assign refill_gnt_o = bus_gnt_i && pick_refill;
  assign ld_gnt_o     = bus_gnt_i && !pick_refill;

  // steer returning beats by id
  assign refill_beat_valid_o = beat_valid_i && (beat_id_i == ID_IFETCH);
  assign ld_rvalid_o         = beat_valid_i && (beat_id_i == ID_LOAD);
  assign ld_rdata_o          = beat_data_i;   // whole beat, load side picks bytes

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      owner_q <= ID_NONE;
    end else if (bus_gnt_i) begin
      owner_q <= bus_id_o;        // lock the winner
    end else if (beat_valid_i && beat_last_i) begin
      owner_q <= ID_NONE;
    end
  end

  // slave must echo the id of the burst that holds the bus
  a_beat_owner: assert property (@(posedge clk) disable iff (!rst_n)
    beat_valid_i |-> (beat_id_i == owner_q))
    else $error("mem_arbiter: beat id %0d, owner %0d", beat_id_i, owner_q);

endmodule

/* logic/axi_rd_master.sv */
module axi_rd_master import fetch_pkg::*, bus_pkg::*; (
  input  logic                 clk,
  input  logic                 rst_n,
  // arbiter side
  input  logic                 bus_req_i,
  input  logic [XLEN-1:0]      bus_addr_i,
  input  bus_id_e              bus_id_i,
  input  logic [AXI_LEN_W-1:0] bus_len_i,
  output logic                 bus_gnt_o,
  output logic                 beat_valid_o,
  output logic [BUS_DW-1:0]    beat_data_o,
  output bus_id_e              beat_id_o,
  output logic                 beat_last_o,
  // ar channel
  output logic                 ar_valid_o,
  input  logic                 ar_ready_i,
  output logic [XLEN-1:0]      ar_addr_o,
  output logic [BUS_ID_W-1:0]  ar_id_o,
  output logic [AXI_LEN_W-1:0] ar_len_o,
  output logic [1:0]           ar_burst_o,
  // r channel
  input  logic                 r_valid_i,
  output logic                 r_ready_o,
  input  logic [BUS_DW-1:0]    r_data_i,
  input  logic [BUS_ID_W-1:0]  r_id_i,
  input  logic                 r_last_i,
  input  logic [1:0]           r_resp_i
);

  typedef enum logic [1:0] {M_IDLE, M_ADDR, M_DATA} mstate_e;

  mstate_e              state_q;
  logic [XLEN-1:0]      addr_q;
  bus_id_e              id_q;
  logic [AXI_LEN_W-1:0] len_q;
  logic [AXI_LEN_W-1:0] beat_cnt_q;   // beats seen in this burst
  logic                 r_hs;

  assign bus_gnt_o = (state_q == M_IDLE) && bus_req_i;   // same cycle as request

  // ar held stable from the cycle after grant until accepted
  assign ar_valid_o = (state_q == M_ADDR);
  assign ar_addr_o  = addr_q;
  assign ar_id_o    = id_q;
  assign ar_len_o   = len_q;
  assign ar_burst_o = BURST_INCR;

  // every burst here has a sink with room for it
  assign r_ready_o = 1'b1;
  assign r_hs      = r_valid_i && r_ready_o;

  assign beat_valid_o = (state_q == M_DATA) && r_hs;
  assign beat_data_o  = r_data_i;
  assign beat_id_o    = bus_id_e'(r_id_i);
  assign beat_last_o  = r_last_i;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q    <= M_IDLE;
      beat_cnt_q <= '0;
    end else begin
      case (state_q)
        M_IDLE: if (bus_gnt_o) state_q <= M_ADDR;
        M_ADDR: begin
          if (ar_ready_i) begin
            state_q    <= M_DATA;
            beat_cnt_q <= '0;
          end
        end
        M_DATA: begin
          if (r_hs) begin
            beat_cnt_q <= beat_cnt_q + 1'b1;
            if (r_last_i) state_q <= M_IDLE;   // bus free again
          end
        end
        default: state_q <= M_IDLE;
      endcase
    end
  end

  // request fields, captured at grant
  always_ff @(posedge clk) begin
    if (bus_gnt_o) begin
      addr_q <= bus_addr_i;
      id_q   <= bus_id_i;
      len_q  <= bus_len_i;
    end
  end

  // rlast must line up with the arlen we sent
  a_last_on_final: assert property (@(posedge clk) disable iff (!rst_n)
    (state_q == M_DATA && r_hs) |-> (r_last_i == (beat_cnt_q == len_q)))
    else $error("axi_rd_master: rlast on beat %0d of len %0d", beat_cnt_q, len_q);

  // slave error responses are not handled by fetch or loads
  a_resp_okay: assert property (@(posedge clk) disable iff (!rst_n)
    (state_q == M_DATA && r_hs) |-> (r_resp_i == RESP_OKAY))
    else $error("axi_rd_master: rresp %0b on id %0d", r_resp_i, r_id_i);

endmodule

/* logic/if_stage.sv */
module if_stage import fetch_pkg::*, bus_pkg::*; #(
  parameter int FETCH_CREDITS = 4,
  parameter int NUM_LINES     = 16,
  parameter int LINE_BEATS    = 2
) (
  input  logic                 clk,
  input  logic                 rst_n,
  // execute and decode
  input  logic                 redirect_valid_i,
  input  logic [XLEN-1:0]      redirect_pc_i,
  input  logic                 inst_credit_i,
  output logic                 inst_valid_o,
  output logic [INST_W-1:0]    inst_o,
  output logic [XLEN-1:0]      inst_pc_o,
  // data-stage loads
  input  logic                 ld_req_i,
  input  logic [XLEN-1:0]      ld_addr_i,
  output logic                 ld_gnt_o,
  output logic                 ld_rvalid_o,
  output logic [BUS_DW-1:0]    ld_rdata_o,
  // axi read
  output logic                 ar_valid_o,
  input  logic                 ar_ready_i,
  output logic [XLEN-1:0]      ar_addr_o,
  output logic [BUS_ID_W-1:0]  ar_id_o,
  output logic [AXI_LEN_W-1:0] ar_len_o,
  output logic [1:0]           ar_burst_o,
  input  logic                 r_valid_i,
  output logic                 r_ready_o,
  input  logic [BUS_DW-1:0]    r_data_i,
  input  logic [BUS_ID_W-1:0]  r_id_i,
  input  logic                 r_last_i,
  input  logic [1:0]           r_resp_i
);

  logic                 fetch_req, fetch_kill, fetch_done, deliver;
  logic [XLEN-1:0]      fetch_addr;
  logic [INST_W-1:0]    fetch_word;
  logic                 refill_req, refill_gnt, refill_beat_valid;
  logic [XLEN-1:0]      refill_addr;
  logic                 bus_req, bus_gnt, beat_valid, beat_last;
  logic [XLEN-1:0]      bus_addr;
  bus_id_e              bus_id, beat_id;
  logic [AXI_LEN_W-1:0] bus_len;
  logic [BUS_DW-1:0]    beat_data;

  assign inst_valid_o = fetch_done && deliver;
  assign inst_o       = inst_valid_o ? fetch_word : NOP_INST;   // bubble otherwise
  // pc_gen has already stepped past the fetch being answered
  assign inst_pc_o    = fetch_addr - XLEN'(INST_BYTES);

  pc_gen #(.FETCH_CREDITS(FETCH_CREDITS)) u_pc_gen (
    .clk, .rst_n, .redirect_valid_i, .redirect_pc_i, .inst_credit_i,
    .fetch_done_i(fetch_done), .fetch_req_o(fetch_req), .fetch_addr_o(fetch_addr),
    .fetch_kill_o(fetch_kill), .deliver_o(deliver)
  );

  icache #(.NUM_LINES(NUM_LINES), .LINE_BEATS(LINE_BEATS)) u_icache (
    .clk, .rst_n, .fetch_req_i(fetch_req), .fetch_addr_i(fetch_addr),
    .fetch_kill_i(fetch_kill), .fetch_done_o(fetch_done), .fetch_word_o(fetch_word),
    .refill_req_o(refill_req), .refill_addr_o(refill_addr), .refill_gnt_i(refill_gnt),
    .refill_beat_valid_i(refill_beat_valid), .refill_data_i(beat_data),
    .refill_last_i(beat_last)
  );

  mem_arbiter #(.LINE_BEATS(LINE_BEATS)) u_mem_arbiter (
    .clk, .rst_n, .refill_req_i(refill_req), .refill_addr_i(refill_addr),
    .refill_gnt_o(refill_gnt), .ld_req_i, .ld_addr_i, .ld_gnt_o,
    .bus_req_o(bus_req), .bus_addr_o(bus_addr), .bus_id_o(bus_id), .bus_len_o(bus_len),
    .bus_gnt_i(bus_gnt), .beat_valid_i(beat_valid), .beat_id_i(beat_id),
    .beat_data_i(beat_data), .beat_last_i(beat_last),
    .refill_beat_valid_o(refill_beat_valid), .ld_rvalid_o, .ld_rdata_o
  );

  axi_rd_master u_axi_rd_master (
    .clk, .rst_n, .bus_req_i(bus_req), .bus_addr_i(bus_addr), .bus_id_i(bus_id),
    .bus_len_i(bus_len), .bus_gnt_o(bus_gnt), .beat_valid_o(beat_valid),
    .beat_data_o(beat_data), .beat_id_o(beat_id), .beat_last_o(beat_last),
    .ar_valid_o, .ar_ready_i, .ar_addr_o, .ar_id_o, .ar_len_o, .ar_burst_o,
    .r_valid_i, .r_ready_o, .r_data_i, .r_id_i, .r_last_i, .r_resp_i
  );

endmodule

/* verification/axi_mem_model.sv */
module axi_mem_model import fetch_pkg::*, bus_pkg::*; (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 ar_valid_i,
  output logic                 ar_ready_o,
  input  logic [XLEN-1:0]      ar_addr_i,
  input  logic [BUS_ID_W-1:0]  ar_id_i,
  input  logic [AXI_LEN_W-1:0] ar_len_i,
  output logic                 r_valid_o,
  output logic [BUS_DW-1:0]    r_data_o,
  output logic [BUS_ID_W-1:0]  r_id_o,
  output logic                 r_last_o,
  output logic [1:0]           r_resp_o
);

  timeunit 1ns;
  timeprecision 100ps;

  integer               seed = 41;
  logic [XLEN-1:0]      base;   // burst start
  logic [BUS_ID_W-1:0]  id;
  logic [AXI_LEN_W-1:0] len;

  // upper half is the word at a+4
  function automatic logic [BUS_DW-1:0] beat_at(logic [XLEN-1:0] a);
    logic [31:0] lo;
    lo = {a[31:3], 3'b000};
    return {(lo + 32'd4) ^ 32'h5A5A_0000, lo ^ 32'h5A5A_0000};
  endfunction

  initial begin
    ar_ready_o = 1'b0;
    r_valid_o  = 1'b0;
    r_data_o   = '0;
    r_id_o     = '0;
    r_last_o   = 1'b0;
    r_resp_o   = RESP_OKAY;   // never errors
    forever begin
      @(negedge clk);
      if (rst_n && ar_valid_i) begin
        base = ar_addr_i;   // held stable until accepted
        id   = ar_id_i;
        len  = ar_len_i;
        repeat ($unsigned($random(seed)) % 4) @(negedge clk);   // slow ready
        ar_ready_o = 1'b1;
        @(negedge clk);
        ar_ready_o = 1'b0;
        for (int b = 0; b <= len; b++) begin
          r_valid_o = 1'b1;   // back to back beats
          r_data_o  = beat_at(base + XLEN'(8 * b));
          r_id_o    = id;
          r_last_o  = (b == len);
          @(negedge clk);
        end
        r_valid_o = 1'b0;
        r_last_o  = 1'b0;
      end
    end
  end

endmodule

/* verification/if_checker.sv */
module if_checker import fetch_pkg::*, bus_pkg::*; #(
  parameter int FETCH_CREDITS = 4,
  parameter int LINE_BEATS    = 2
) (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 redirect_valid_i,
  input  logic [XLEN-1:0]      redirect_pc_i,
  input  logic                 inst_credit_i,
  input  logic                 inst_valid_i,
  input  logic [INST_W-1:0]    inst_i,
  input  logic [XLEN-1:0]      inst_pc_i,
  input  logic                 ld_gnt_i,
  input  logic                 ld_rvalid_i,
  input  logic [BUS_DW-1:0]    ld_rdata_i,
  input  logic [BUS_DW-1:0]    ld_expect_i,    // from the vector line
  input  logic                 ar_valid_i,
  input  logic                 ar_ready_i,
  input  logic [XLEN-1:0]      ar_addr_i,
  input  logic [BUS_ID_W-1:0]  ar_id_i,
  input  logic [AXI_LEN_W-1:0] ar_len_i,
  input  logic [1:0]           ar_burst_i,
  input  logic                 r_ready_i,
  input  logic                 expect_full_i,  // decode buffer should be full now
  output int                   value_errs_o,
  output int                   other_errs_o
);

  timeunit 1ns;
  timeprecision 100ps;

  localparam int LINE_BYTES = LINE_BEATS * BUS_DW / 8;

  logic [XLEN-1:0]   exp_pc;        // next pc decode should see
  int                outstanding;   // delivered, credit not yet back
  logic [BUS_DW-1:0] ld_exp_q[$];
  logic [XLEN-1:0]   refilled_q[$]; // one entry per refill burst seen
  logic              ar_wait;       // ar pending last cycle
  logic [XLEN-1:0]   ar_addr_prev;

  function automatic logic [INST_W-1:0] mem_word(logic [XLEN-1:0] a);
    return a[31:0] ^ 32'h5A5A_0000;
  endfunction

  // ar handshakes seen so far for one line address
  function automatic int refill_count(logic [XLEN-1:0] line);
    int n;
    n = 0;
    for (int i = 0; i < refilled_q.size(); i++) begin
      if (refilled_q[i] == line) n++;
    end
    return n;
  endfunction

  task automatic compare(string name, logic [63:0] exp, logic [63:0] got);
    if (exp !== got) begin
      $display("[ERROR] %0t %s expected %h got %h", $time, name, exp, got);
      value_errs_o++;
    end
  endtask

  task automatic report_failure(string what);
    $display("%0t %s", $time, what);
    other_errs_o++;
  endtask

  initial begin
    value_errs_o = 0;
    other_errs_o = 0;
  end

  always @(posedge clk) begin
    if (!rst_n) begin
      exp_pc      = RESET_PC;
      outstanding = 0;
      ar_wait     = 1'b0;
      if (inst_valid_i || ar_valid_i || ld_gnt_i || ld_rvalid_i || !r_ready_i)
        report_failure("outputs not idle during reset");
    end else begin
      // anything landing with the redirect belongs to the old path
      if (redirect_valid_i) exp_pc = redirect_pc_i;
      if (inst_valid_i) begin
        compare("inst_pc_o", exp_pc, inst_pc_i);
        compare("inst_o", mem_word(exp_pc), inst_i);
        exp_pc = exp_pc + 4;   // pc+4 path
        outstanding++;
      end
      if (inst_credit_i) outstanding--;
      if (outstanding > FETCH_CREDITS || outstanding < 0)
        report_failure("decode buffer holds more than its credits allow");
      if (expect_full_i) compare("buffered instructions", FETCH_CREDITS, outstanding);

      if (!r_ready_i) report_failure("r_ready_o went low outside reset");

      // ar must not move while waiting for ready
      if (ar_wait && !(ar_valid_i && ar_addr_i == ar_addr_prev))
        report_failure("ar channel changed before it was accepted");
      ar_wait      = ar_valid_i && !ar_ready_i;
      ar_addr_prev = ar_addr_i;
      if (ar_valid_i && ar_ready_i) begin
        compare("ar_burst_o", BURST_INCR, ar_burst_i);
        if (ar_id_i == ID_IFETCH) begin
          compare("ar_len_o", LINE_BEATS - 1, ar_len_i);
          if (ar_addr_i % LINE_BYTES != 0) report_failure("refill address not line aligned");
          refilled_q.push_back(ar_addr_i);
          if (refill_count(ar_addr_i) > 1) report_failure("cached line was fetched again");
        end else if (ar_id_i == ID_LOAD) begin
          compare("ar_len_o", 0, ar_len_i);   // single beat
        end else begin
          report_failure("ar_id_o is neither fetch nor load");
        end
      end

      if (ld_gnt_i) ld_exp_q.push_back(ld_expect_i);
      if (ld_rvalid_i) begin
        if (ld_exp_q.size() == 0) report_failure("load data returned with no load granted");
        else compare("ld_rdata_o", ld_exp_q.pop_front(), ld_rdata_i);
      end
    end
  end

endmodule

/* verification/tb_if_stage.sv */
module tb_if_stage import fetch_pkg::*, bus_pkg::*; ();

  timeunit 1ns;
  timeprecision 100ps;

  localparam int FETCH_CREDITS = 4;
  localparam int LINE_BEATS    = 2;

  logic                 clk = 1'b0;
  logic                 rst_n;
  logic                 redirect_valid_i, inst_credit_i, inst_valid_o;
  logic [XLEN-1:0]      redirect_pc_i, inst_pc_o, ld_addr_i, ar_addr_o;
  logic [INST_W-1:0]    inst_o;
  logic                 ld_req_i, ld_gnt_o, ld_rvalid_o;
  logic [BUS_DW-1:0]    ld_rdata_o, r_data_i, ld_expect;
  logic                 ar_valid_o, ar_ready_i, r_valid_i, r_ready_o, r_last_i;
  logic [BUS_ID_W-1:0]  ar_id_o, r_id_i;
  logic [AXI_LEN_W-1:0] ar_len_o;
  logic [1:0]           ar_burst_o, r_resp_i;
  logic                 expect_full;
  int                   value_errs, other_errs;
  int                   tb_errs = 0;   // bad vector lines
  integer               seed = 41;
  int                   cycles = 0;
  int                   limit = 0;
  int                   delivered = 0;
  int                   returned = 0;
  byte                  cmd_q[$];
  logic [63:0]          arg_q[$];
  logic [63:0]          exp_q[$];

  always #20 clk = ~clk;   // 40 ns period

  if_stage #(.FETCH_CREDITS(FETCH_CREDITS), .LINE_BEATS(LINE_BEATS)) i_dut (.*);

  axi_mem_model i_mem (
    .clk, .rst_n, .ar_valid_i(ar_valid_o), .ar_ready_o(ar_ready_i), .ar_addr_i(ar_addr_o),
    .ar_id_i(ar_id_o), .ar_len_i(ar_len_o), .r_valid_o(r_valid_i), .r_data_o(r_data_i),
    .r_id_o(r_id_i), .r_last_o(r_last_i), .r_resp_o(r_resp_i)
  );

  if_checker #(.FETCH_CREDITS(FETCH_CREDITS), .LINE_BEATS(LINE_BEATS)) i_chk (
    .clk, .rst_n, .redirect_valid_i, .redirect_pc_i, .inst_credit_i,
    .inst_valid_i(inst_valid_o), .inst_i(inst_o), .inst_pc_i(inst_pc_o),
    .ld_gnt_i(ld_gnt_o), .ld_rvalid_i(ld_rvalid_o), .ld_rdata_i(ld_rdata_o),
    .ld_expect_i(ld_expect), .ar_valid_i(ar_valid_o), .ar_ready_i, .ar_addr_i(ar_addr_o),
    .ar_id_i(ar_id_o), .ar_len_i(ar_len_o), .ar_burst_i(ar_burst_o), .r_ready_i(r_ready_o),
    .expect_full_i(expect_full), .value_errs_o(value_errs), .other_errs_o(other_errs)
  );

  // decode side, one entry per instruction handed over
  always @(posedge clk) if (rst_n && inst_valid_o) delivered++;

  always @(posedge clk) begin
    cycles++;
    if (limit != 0 && cycles >= limit) begin
      $display("timeout after %0d cycles, vectors did not finish", cycles);
      $display("errors: %0d value, %0d other, %0d vector", value_errs, other_errs, tb_errs);
      $display("Done: errors found");
      $finish;
    end
  end

  // letter, then two hex numbers; # lines are comments
  task automatic read_vectors(output bit ok);
    int          fd;
    int          c;
    int          n;
    logic [63:0] a;
    logic [63:0] e;
    fd = $fopen("verification/if_vectors.txt", "r");
    ok = (fd != 0);
    if (ok) begin
      c = $fgetc(fd);
      while (c != -1) begin
        if (c == "#") begin
          while (c != "\n" && c != -1) c = $fgetc(fd);
        end else if (c >= "A" && c <= "Z") begin
          n = $fscanf(fd, "%h %h", a, e);
          if (n == 2) begin
            cmd_q.push_back(c);
            arg_q.push_back(a);
            exp_q.push_back(e);
          end else begin
            $display("vector line for command %c is missing its numbers", c);
            tb_errs++;
          end
        end
        c = $fgetc(fd);
      end
      $fclose(fd);
    end
  endtask

  // one pulse per consumed instruction, random gaps
  task automatic return_credits(int n);
    repeat (n) begin
      while (delivered <= returned) @(negedge clk);
      repeat ($unsigned($random(seed)) % 4) @(negedge clk);
      inst_credit_i = 1'b1;
      @(negedge clk);
      inst_credit_i = 1'b0;
      returned++;
    end
  endtask

  // decode eats one instruction first so a fetch is in flight at the redirect
  task automatic redirect(logic [XLEN-1:0] pc);
    return_credits(1);
    @(negedge clk);
    redirect_valid_i = 1'b1;
    redirect_pc_i    = pc;
    @(negedge clk);
    redirect_valid_i = 1'b0;
  endtask

  task automatic load(logic [XLEN-1:0] a, logic [BUS_DW-1:0] e);
    ld_req_i  = 1'b1;   // held until granted
    ld_addr_i = a;
    ld_expect = e;
    do @(posedge clk); while (!ld_gnt_o);
    @(negedge clk);
    ld_req_i = 1'b0;
    do @(posedge clk); while (!ld_rvalid_o);
    @(negedge clk);
  endtask

  task automatic idle(int n);
    repeat (n) @(negedge clk);
    expect_full = 1'b1;   // fetch should have filled decode by now
    @(negedge clk);
    expect_full = 1'b0;
  endtask

  initial begin
    bit ok;
    rst_n            = 1'b0;
    redirect_valid_i = 1'b0;
    redirect_pc_i    = '0;
    inst_credit_i    = 1'b0;
    ld_req_i         = 1'b0;
    ld_addr_i        = '0;
    ld_expect        = '0;
    expect_full      = 1'b0;
    read_vectors(ok);
    if (!ok) begin
      $display("could not open verification/if_vectors.txt");
      $display("Done: errors found");
      $finish;
    end else begin
      limit = 40 * cmd_q.size() + 200;
      repeat (16) @(negedge clk);
      rst_n = 1'b1;
      for (int i = 0; i < cmd_q.size(); i++) begin
        case (cmd_q[i])
          "C": return_credits(arg_q[i]);
          "R": redirect(arg_q[i]);
          "L": load(arg_q[i], exp_q[i]);
          "W": idle(arg_q[i]);
          default: begin
            $display("unknown vector command %c on entry %0d", cmd_q[i], i);
            tb_errs++;
          end
        endcase
      end
      repeat (4) @(negedge clk);
      $display("errors: %0d value, %0d other, %0d vector", value_errs, other_errs, tb_errs);
      if (value_errs + other_errs + tb_errs == 0) begin
        $display("Done: no errors");
      end else begin
        $display("Done: errors found");
      end
      $finish;
    end
  end

endmodule

/* src.f */
logic/fetch_pkg.sv
logic/bus_pkg.sv
logic/pc_gen.sv
logic/icache.sv
logic/mem_arbiter.sv
logic/axi_rd_master.sv
logic/if_stage.sv
verification/axi_mem_model.sv
verification/if_checker.sv
verification/tb_if_stage.sv

/* verification/if_vectors.txt */
# cmd arg expected, all numbers hex
# C n credits back, R pc redirect, L addr load with expected beat, W n idle cycles
W 28 0
C 6 0
L 80001000 DA5A1004DA5A1000
W 28 0
R 80000080 0
C 5 0
L 80001008 DA5A100CDA5A1008
W 28 0
R 80000004 0
C 6 0
W 28 0
R 80000090 0
C 3 0
L 80002010 DA5A2014DA5A2010
W 28 0
C 8 0
L 80000F00 DA5A0F04DA5A0F00
W 28 0
